/* logic/control_unit.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module control_unit (
    input  rv_pkg::word_t instr_i,
    input  logic          zero_i,
    output rv_pkg::ctrl_t ctrl_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb
    begin
        // anything not matched below stays a no-op
        ctrl_o.reg_write  = 1'b0;
        ctrl_o.mem_write  = 1'b0;
        ctrl_o.mem_size   = rv_pkg::MEM_WORD;
        ctrl_o.result_src = rv_pkg::RES_ALU;
        ctrl_o.alu_op     = rv_pkg::ALU_ADD;
        ctrl_o.alu_src    = 1'b0;
        ctrl_o.imm_src    = rv_pkg::IMM_I;
        ctrl_o.pc_src     = rv_pkg::PC_PLUS4;

        case (opcode)
            `RV_OP_LOAD:
            begin
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.result_src = rv_pkg::RES_MEM;
                case (funct3)
                    3'b000: ctrl_o.mem_size = rv_pkg::MEM_BYTE; // lb
                    3'b001: ctrl_o.mem_size = rv_pkg::MEM_HALF; // lh
                    default: ctrl_o.mem_size = rv_pkg::MEM_WORD;
                endcase
                ctrl_o.reg_write = (funct3 inside {3'b000, 3'b001, 3'b010});
            end
            `RV_OP_STORE:
            begin
                ctrl_o.alu_src = 1'b1;
                ctrl_o.imm_src = rv_pkg::IMM_S;
                case (funct3)
                    3'b000: ctrl_o.mem_size = rv_pkg::MEM_BYTE; // sb
                    3'b001: ctrl_o.mem_size = rv_pkg::MEM_HALF; // sh
                    default: ctrl_o.mem_size = rv_pkg::MEM_WORD;
                endcase
                ctrl_o.mem_write = (funct3 inside {3'b000, 3'b001, 3'b010});
            end
            `RV_OP_RTYPE:
            begin
                ctrl_o.reg_write = 1'b1;
                case (funct3)
                    3'b000: ctrl_o.alu_op = (funct7 == 7'b0100000) ? rv_pkg::ALU_SUB
                                                                   : rv_pkg::ALU_ADD;
                    3'b100: ctrl_o.alu_op = rv_pkg::ALU_XOR;
                    3'b110: ctrl_o.alu_op = rv_pkg::ALU_OR;
                    3'b111: ctrl_o.alu_op = rv_pkg::ALU_AND;
                    default: ctrl_o.reg_write = 1'b0; // sll, slt and friends unsupported
                endcase
            end
            `RV_OP_ITYPE:
            begin
                ctrl_o.alu_src = 1'b1;
                case (funct3)
                    3'b000:
                    begin
                        ctrl_o.reg_write = 1'b1; // addi
                    end
                    3'b001:
                    begin
                        ctrl_o.reg_write = 1'b1; // slli
                        ctrl_o.alu_op    = rv_pkg::ALU_SLL;
                    end
                    default: ctrl_o.reg_write = 1'b0;
                endcase
            end
            `RV_OP_BRANCH:
            begin
                ctrl_o.imm_src = rv_pkg::IMM_B;
                ctrl_o.alu_op  = rv_pkg::ALU_SUB; // zero flag is rs1 == rs2
                if ((funct3 == 3'b000 && zero_i) || (funct3 == 3'b001 && !zero_i))
                    ctrl_o.pc_src = rv_pkg::PC_BRANCH_TARGET;
            end
            `RV_OP_JAL:
            begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.imm_src    = rv_pkg::IMM_J;
                ctrl_o.result_src = rv_pkg::RES_PC4; // link
                ctrl_o.pc_src     = rv_pkg::PC_BRANCH_TARGET;
            end
            `RV_OP_JALR:
            begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.result_src = rv_pkg::RES_PC4;
                ctrl_o.pc_src     = rv_pkg::PC_ALU_TARGET; // rs1 + imm
            end
            default: ;
        endcase
    end

    // a store never writes back, whatever the funct3
    no_store_writeback: assert final (!(ctrl_o.mem_write && ctrl_o.reg_write));

endmodule

/* logic/data_memory.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module data_memory (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              write_en_i,
    input  rv_pkg::mem_size_t size_i,
    input  rv_pkg::word_t     addr_i,
    input  rv_pkg::word_t     wdata_i,
    output rv_pkg::word_t     rdata_o
);

    localparam int ADDR_W = $clog2(`RV_DMEM_BYTES);

    logic [7:0]        mem [`RV_DMEM_BYTES];
    logic [ADDR_W-1:0] a0;
    logic [ADDR_W-1:0] a1;
    logic [ADDR_W-1:0] a2;
    logic [ADDR_W-1:0] a3;

    // upper address bits wrap around the array
    assign a0 = addr_i[ADDR_W-1:0];
    assign a1 = a0 + ADDR_W'(1);
    assign a2 = a0 + ADDR_W'(2);
    assign a3 = a0 + ADDR_W'(3);

    always_ff @(posedge clk_i)
    begin
        if (write_en_i)
        begin
            mem[a0] <= wdata_i[7:0];
            if (size_i != rv_pkg::MEM_BYTE)
                mem[a1] <= wdata_i[15:8];
            if (size_i == rv_pkg::MEM_WORD)
            begin
                mem[a2] <= wdata_i[23:16];
                mem[a3] <= wdata_i[31:24];
            end
        end
    end

    // little endian, sign extended loads
    always_comb
    begin
        case (size_i)
            rv_pkg::MEM_BYTE: rdata_o = {{24{mem[a0][7]}}, mem[a0]};
            rv_pkg::MEM_HALF: rdata_o = {{16{mem[a1][7]}}, mem[a1], mem[a0]};
            default:          rdata_o = {mem[a3], mem[a2], mem[a1], mem[a0]};
        endcase
    end

    store_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        write_en_i |->
            !(size_i == rv_pkg::MEM_HALF && addr_i[0]) &&
            !(size_i == rv_pkg::MEM_WORD && addr_i[1:0] != 2'b00));

endmodule

/* logic/datapath.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module datapath (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 run_i,
    input  rv_pkg::word_t        instr_i,
    input  rv_pkg::ctrl_t        ctrl_i,
    input  rv_pkg::word_t        load_data_i,
    input  rv_pkg::reg_idx_t     dbg_idx_i,
    output rv_pkg::imem_addr_t   pc_o,
    output logic                 zero_o,
    output rv_pkg::word_t        alu_result_o,
    output rv_pkg::word_t        store_data_o,
    output rv_pkg::word_t        dbg_data_o
);

    rv_pkg::word_t    pc_q;          // byte address
    rv_pkg::word_t    pc_plus4;
    rv_pkg::word_t    pc_next;
    rv_pkg::word_t    regs [`RV_NREGS];
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    rd1;
    rv_pkg::word_t    rd2;
    rv_pkg::word_t    imm;
    rv_pkg::word_t    src_b;
    rv_pkg::word_t    alu_y;
    rv_pkg::word_t    result;

    assign rs1 = instr_i[19:15];
    assign rs2 = instr_i[24:20];
    assign rd  = instr_i[11:7];

    assign rd1 = regs[rs1]; // x0 is never written, so it reads 0
    assign rd2 = regs[rs2];

    always_comb
    begin
        case (ctrl_i.imm_src)
            rv_pkg::IMM_S: imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            rv_pkg::IMM_B: imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                  instr_i[30:25], instr_i[11:8], 1'b0};
            rv_pkg::IMM_J: imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                                  instr_i[20], instr_i[30:21], 1'b0};
            default:       imm = {{20{instr_i[31]}}, instr_i[31:20]};
        endcase
    end

    assign src_b = ctrl_i.alu_src ? imm : rd2;

    always_comb
    begin
        case (ctrl_i.alu_op)
            rv_pkg::ALU_SUB: alu_y = rd1 - src_b;
            rv_pkg::ALU_AND: alu_y = rd1 & src_b;
            rv_pkg::ALU_OR:  alu_y = rd1 | src_b;
            rv_pkg::ALU_XOR: alu_y = rd1 ^ src_b;
            rv_pkg::ALU_SLL: alu_y = rd1 << src_b[4:0]; // shamt only
            default:         alu_y = rd1 + src_b;
        endcase
    end

    assign zero_o       = (alu_y == '0);
    assign alu_result_o = alu_y;
    assign store_data_o = rd2;

    assign pc_plus4 = pc_q + 32'd4;

    always_comb
    begin
        case (ctrl_i.result_src)
            rv_pkg::RES_MEM: result = load_data_i;
            rv_pkg::RES_PC4: result = pc_plus4;
            default:         result = alu_y;
        endcase
    end

    always_comb
    begin
        case (ctrl_i.pc_src)
            rv_pkg::PC_BRANCH_TARGET: pc_next = pc_q + imm;
            rv_pkg::PC_ALU_TARGET:    pc_next = {alu_y[31:1], 1'b0}; // jalr drops bit 0
            default:                  pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            pc_q <= '0;
        else if (run_i)
            pc_q <= pc_next;
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            for (int i = 0; i < `RV_NREGS; i++)
                regs[i] <= '0;
        end
        else if (run_i && ctrl_i.reg_write && rd != '0)
            regs[rd] <= result;
    end

    assign pc_o       = pc_q[$bits(rv_pkg::imem_addr_t)+1:2];
    assign dbg_data_o = regs[dbg_idx_i];

    x0_stays_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        regs[0] == '0);

endmodule

/* logic/program_loader.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module program_loader (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               req_i,
    input  rv_pkg::host_req_t  host_req_i,
    output logic               ack_o,
    output rv_pkg::word_t      rdata_o,
    input  rv_pkg::imem_addr_t pc_i,
    output rv_pkg::word_t      instr_o,
    output logic               run_o,
    output rv_pkg::reg_idx_t   dbg_idx_o,
    input  rv_pkg::word_t      dbg_data_i
);

    typedef enum logic {LD_IDLE, LD_ACKED} ld_state_t;

    ld_state_t     state_q;
    logic          run_q;
    rv_pkg::word_t rdata_q;
    rv_pkg::word_t imem [`RV_IMEM_WORDS];
    logic          take_cmd;

    assign take_cmd = (state_q == LD_IDLE) && req_i; // once per req phase

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            state_q <= LD_IDLE;
            run_q   <= 1'b0;
            rdata_q <= '0;
        end
        else
        begin
            case (state_q)
                LD_IDLE:
                begin
                    if (req_i)
                    begin
                        state_q <= LD_ACKED;
                        if (host_req_i.cmd == rv_pkg::CMD_SET_RUN)
                            run_q <= host_req_i.wdata[0];
                        if (host_req_i.cmd == rv_pkg::CMD_READ_REG)
                            rdata_q <= dbg_data_i;
                    end
                end
                default:
                begin
                    if (!req_i)
                        state_q <= LD_IDLE;
                end
            endcase
        end
    end

    // program writes only while halted
    always_ff @(posedge clk_i)
    begin
        if (rst_n_i && take_cmd && host_req_i.cmd == rv_pkg::CMD_LOAD_INSTR && !run_q)
            imem[host_req_i.addr] <= host_req_i.wdata;
    end

    assign dbg_idx_o = host_req_i.addr[$bits(rv_pkg::reg_idx_t)-1:0];
    assign instr_o   = run_q ? imem[pc_i] : '0; // halted core sees a no-op
    assign run_o     = run_q;
    assign ack_o     = (state_q == LD_ACKED);
    assign rdata_o   = rdata_q;

    ack_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_o) |-> $past(req_i));

endmodule

/* logic/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data path width
`define RV_XLEN         32

// architectural registers, x0 included
`define RV_NREGS        32

// program memory depth in words
`define RV_IMEM_WORDS   64

// data memory size in bytes
`define RV_DMEM_BYTES   256

// major opcodes seen by the decoder
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_RTYPE     7'b0110011
`define RV_OP_ITYPE     7'b0010011
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111

`endif

/* logic/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              req_i,
    input  rv_pkg::host_req_t host_req_i,
    output logic              ack_o,
    output rv_pkg::word_t     rdata_o
);

    logic               run;
    rv_pkg::word_t      instr;
    rv_pkg::ctrl_t      ctrl;
    logic               zero;
    rv_pkg::imem_addr_t pc;
    rv_pkg::word_t      alu_result;
    rv_pkg::word_t      store_data;
    rv_pkg::word_t      load_data;
    rv_pkg::reg_idx_t   dbg_idx;
    rv_pkg::word_t      dbg_data;

    program_loader loader_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (req_i),
        .host_req_i (host_req_i),
        .ack_o      (ack_o),
        .rdata_o    (rdata_o),
        .pc_i       (pc),
        .instr_o    (instr),
        .run_o      (run),
        .dbg_idx_o  (dbg_idx),
        .dbg_data_i (dbg_data)
    );

    control_unit decoder_i (
        .instr_i (instr),
        .zero_i  (zero),
        .ctrl_o  (ctrl)
    );

    datapath datapath_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .run_i        (run),
        .instr_i      (instr),
        .ctrl_i       (ctrl),
        .load_data_i  (load_data),
        .dbg_idx_i    (dbg_idx),
        .pc_o         (pc),
        .zero_o       (zero),
        .alu_result_o (alu_result),
        .store_data_o (store_data),
        .dbg_data_o   (dbg_data)
    );

    // a halted core fetches a no-op and never stores
    data_memory dmem_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .write_en_i (ctrl.mem_write),
        .size_i     (ctrl.mem_size),
        .addr_i     (alu_result),
        .wdata_i    (store_data),
        .rdata_o    (load_data)
    );

endmodule

/* logic/rv_pkg.sv */
`include "rv_consts.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]               word_t;
    typedef logic [$clog2(`RV_NREGS)-1:0]      reg_idx_t;
    typedef logic [$clog2(`RV_IMEM_WORDS)-1:0] imem_addr_t;

    // ALU function codes
    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_XOR = 3'b100,
        ALU_SLL = 3'b101
    } alu_op_t;

    typedef enum logic [1:0] {IMM_I, IMM_S, IMM_B, IMM_J} imm_src_t;

    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} result_src_t;

    typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH_TARGET, PC_ALU_TARGET} pc_src_t;

    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        mem_size_t   mem_size;   // loads and stores alike
        result_src_t result_src;
        alu_op_t     alu_op;
        logic        alu_src;    // 1 selects the immediate
        imm_src_t    imm_src;
        pc_src_t     pc_src;
    } ctrl_t;

    typedef enum logic [1:0] {CMD_LOAD_INSTR, CMD_SET_RUN, CMD_READ_REG} host_cmd_e;

    typedef struct packed {
        host_cmd_e  cmd;
        imem_addr_t addr;   // also the register index for READ_REG
        word_t      wdata;
    } host_req_t;

endpackage

/* sources.f */
+incdir+logic
logic/rv_pkg.sv
logic/control_unit.sv
logic/datapath.sv
logic/data_memory.sv
logic/program_loader.sv
logic/rv_core_top.sv
verification/tb_clock.sv
verification/rv_core_tb.sv

/* verification/rv_core_tb.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_tb;

    localparam int PROG_LEN    = 35;
    localparam int RUN_CYCLES  = PROG_LEN + 10; // one instruction per clock plus slack
    localparam int ACK_TIMEOUT = 20;

    logic              clk;
    logic              rst_n;
    logic              req;
    rv_pkg::host_req_t host_req;
    logic              ack;
    rv_pkg::word_t     rdata;

    rv_pkg::word_t prog [PROG_LEN];
    rv_pkg::word_t exp_regs [`RV_NREGS];
    rv_pkg::word_t exp_rdata;
    logic [11:0]   imm_a;
    logic [11:0]   imm_b;
    logic [4:0]    shamt;

    tb_clock clk_gen_i (.clk_o(clk));

    rv_core_top dut_i (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .req_i      (req),
        .host_req_i (host_req),
        .ack_o      (ack),
        .rdata_o    (rdata)
    );

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_value(input string name, input rv_pkg::word_t got,
                                input rv_pkg::word_t exp);
        stop_on_error($sformatf("FAILED %s got 0x%08h expected 0x%08h", name, got, exp));
    endtask

    // RV32I encodings
    function automatic rv_pkg::word_t r_instr(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                              logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, `RV_OP_RTYPE};
    endfunction

    function automatic rv_pkg::word_t i_instr(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
                                              logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::word_t s_instr(logic [2:0] f3, logic [4:0] rs1,
                                              logic [4:0] rs2, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic rv_pkg::word_t b_instr(logic [2:0] f3, logic [4:0] rs1,
                                              logic [4:0] rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    function automatic rv_pkg::word_t jal_instr(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
    endfunction

    // one four-phase transaction
    task automatic host_xfer(input rv_pkg::host_cmd_e cmd, input rv_pkg::imem_addr_t addr,
                             input rv_pkg::word_t wdata);
        int waited;
        @(posedge clk);
        host_req.cmd   <= cmd;
        host_req.addr  <= addr;
        host_req.wdata <= wdata;
        req            <= 1'b1;
        waited = 0;
        do
        begin
            @(posedge clk);
            waited++;
            if (waited > ACK_TIMEOUT)
                stop_on_error("timeout waiting for ack_o to rise");
        end
        while (!ack);
        req <= 1'b0;
        waited = 0;
        while (ack)
        begin
            @(posedge clk);
            waited++;
            if (waited > ACK_TIMEOUT)
                stop_on_error("timeout waiting for ack_o to fall");
        end
    endtask

    task automatic load_instr(input rv_pkg::imem_addr_t addr, input rv_pkg::word_t word);
        host_xfer(rv_pkg::CMD_LOAD_INSTR, addr, word);
    endtask

    task automatic set_run(input logic on);
        host_xfer(rv_pkg::CMD_SET_RUN, '0, {31'b0, on});
    endtask

    task automatic read_reg(input int idx);
        exp_rdata <= exp_regs[idx]; // checked by rdata_matches
        host_xfer(rv_pkg::CMD_READ_REG, rv_pkg::imem_addr_t'(idx), '0);
    endtask

    task automatic build_program();
        prog[0]  = i_instr(`RV_OP_ITYPE, 3'b000, 5'd1, 5'd0, imm_a);
        prog[1]  = i_instr(`RV_OP_ITYPE, 3'b000, 5'd2, 5'd0, imm_b);
        prog[2]  = r_instr(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2);  // add
        prog[3]  = r_instr(7'b0100000, 3'b000, 5'd4, 5'd1, 5'd2);  // sub
        prog[4]  = r_instr(7'b0000000, 3'b111, 5'd5, 5'd1, 5'd2);  // and
        prog[5]  = r_instr(7'b0000000, 3'b110, 5'd6, 5'd1, 5'd2);  // or
        prog[6]  = r_instr(7'b0000000, 3'b100, 5'd7, 5'd1, 5'd2);  // xor
        prog[7]  = i_instr(`RV_OP_ITYPE, 3'b001, 5'd8, 5'd1, {7'b0, shamt});
        prog[8]  = i_instr(`RV_OP_ITYPE, 3'b000, 5'd0, 5'd1, 12'd5); // lost in x0
        prog[9]  = i_instr(`RV_OP_ITYPE, 3'b000, 5'd9, 5'd0, 12'd64); // data base
        prog[10] = i_instr(`RV_OP_ITYPE, 3'b000, 5'd10, 5'd0, 12'h123);
        prog[11] = i_instr(`RV_OP_ITYPE, 3'b001, 5'd10, 5'd10, 12'd20);
        prog[12] = i_instr(`RV_OP_ITYPE, 3'b000, 5'd10, 5'd10, 12'h8a5);
        prog[13] = s_instr(3'b010, 5'd9, 5'd10, 12'd0);             // sw
        prog[14] = i_instr(`RV_OP_LOAD, 3'b010, 5'd11, 5'd9, 12'd0); // lw
        prog[15] = i_instr(`RV_OP_LOAD, 3'b001, 5'd12, 5'd9, 12'd0); // lh
        prog[16] = i_instr(`RV_OP_LOAD, 3'b000, 5'd13, 5'd9, 12'd0); // lb
        prog[17] = i_instr(`RV_OP_LOAD, 3'b001, 5'd14, 5'd9, 12'd2);
        prog[18] = s_instr(3'b001, 5'd9, 5'd10, 12'd4);             // sh
        prog[19] = s_instr(3'b000, 5'd9, 5'd1, 12'd1);              // sb into byte 1
        prog[20] = i_instr(`RV_OP_LOAD, 3'b010, 5'd15, 5'd9, 12'd0);
        prog[21] = i_instr(`RV_OP_LOAD, 3'b001, 5'd16, 5'd9, 12'd4);
        prog[22] = i_instr(`RV_OP_LOAD, 3'b000, 5'd17, 5'd9, 12'd3);
        prog[23] = b_instr(3'b000, 5'd1, 5'd1, 13'd8);              // beq taken
        prog[24] = i_instr(`RV_OP_ITYPE, 3'b000, 5'd18, 5'd0, 12'd1);
        prog[25] = b_instr(3'b001, 5'd1, 5'd1, 13'd8);              // bne not taken
        prog[26] = i_instr(`RV_OP_ITYPE, 3'b000, 5'd19, 5'd0, 12'd2);
        prog[27] = jal_instr(5'd20, 21'd8);
        prog[28] = i_instr(`RV_OP_ITYPE, 3'b000, 5'd21, 5'd0, 12'd3);
        prog[29] = i_instr(`RV_OP_ITYPE, 3'b000, 5'd22, 5'd0, 12'd4);
        prog[30] = i_instr(`RV_OP_ITYPE, 3'b000, 5'd24, 5'd0, 12'd132);
        prog[31] = i_instr(`RV_OP_JALR, 3'b000, 5'd23, 5'd24, 12'd1); // odd target
        prog[32] = i_instr(`RV_OP_ITYPE, 3'b000, 5'd25, 5'd0, 12'd5);
        prog[33] = i_instr(`RV_OP_ITYPE, 3'b000, 5'd26, 5'd0, 12'd6);
        prog[34] = jal_instr(5'd0, 21'd0);                          // park here
    endtask

    task automatic build_expected();
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t w;
        a = {{20{imm_a[11]}}, imm_a};
        b = {{20{imm_b[11]}}, imm_b};
        w = (32'h123 << 20) + {{20{1'b1}}, 12'h8a5};
        foreach (exp_regs[i])
            exp_regs[i] = '0;
        exp_regs[1]  = a;
        exp_regs[2]  = b;
        exp_regs[3]  = a + b;
        exp_regs[4]  = a - b;
        exp_regs[5]  = a & b;
        exp_regs[6]  = a | b;
        exp_regs[7]  = a ^ b;
        exp_regs[8]  = a << shamt;
        exp_regs[9]  = 32'd64;
        exp_regs[10] = w;
        exp_regs[11] = w;
        exp_regs[12] = {{16{w[15]}}, w[15:0]};
        exp_regs[13] = {{24{w[7]}}, w[7:0]};
        exp_regs[14] = {{16{w[31]}}, w[31:16]};
        exp_regs[15] = {w[31:16], a[7:0], w[7:0]}; // only byte 1 replaced
        exp_regs[16] = {{16{w[15]}}, w[15:0]};
        exp_regs[17] = {{24{w[31]}}, w[31:24]};
        exp_regs[19] = 32'd2;
        exp_regs[20] = 32'd112;  // link of jal at byte 108
        exp_regs[22] = 32'd4;
        exp_regs[23] = 32'd128;  // link of jalr at byte 124
        exp_regs[24] = 32'd132;
        exp_regs[26] = 32'd6;
    endtask

    rdata_matches: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && host_req.cmd == rv_pkg::CMD_READ_REG) |-> rdata == exp_rdata)
    else
        report_value($sformatf("rdata_o (x%0d)", $sampled(host_req.addr)),
                     $sampled(rdata), $sampled(exp_rdata));

    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
    else
        stop_on_error("ack_o rose without a pending req_i");

    ack_after_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ack) |-> !$past(req))
    else
        stop_on_error("ack_o fell while req_i was still high");

    initial
    begin
        void'($urandom(32'h8370dec3));
        rst_n     = 1'b0;
        req       = 1'b0;
        host_req  = '0;
        exp_rdata = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        reset_ack: assert (ack == 1'b0)
        else
            report_value("ack_o", {31'b0, ack}, '0);
        reset_rdata: assert (rdata == '0)
        else
            report_value("rdata_o", rdata, '0);

        imm_a = 12'($urandom);
        imm_b = 12'($urandom);
        shamt = 5'($urandom);
        build_program();
        build_expected();

        for (int i = 0; i < PROG_LEN; i++)
            load_instr(rv_pkg::imem_addr_t'(i), prog[i]);
        set_run(1'b1);
        // would turn x26 into 99 if the write got through
        load_instr(rv_pkg::imem_addr_t'(33), i_instr(`RV_OP_ITYPE, 3'b000, 5'd26, 5'd0, 12'd99));
        repeat (RUN_CYCLES) @(posedge clk);
        set_run(1'b0);
        // x27 only changes if a halted core still retires this
        load_instr(rv_pkg::imem_addr_t'(34), i_instr(`RV_OP_ITYPE, 3'b000, 5'd27, 5'd0, 12'd7));

        for (int r = 0; r < `RV_NREGS; r++)
            read_reg(r);
        repeat (10) @(posedge clk); // halted core must not move
        for (int r = 0; r < `RV_NREGS; r++)
            read_reg(r);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o
);

    localparam realtime HALF_PERIOD = 4ns; // 8 ns period

    initial
    begin
        clk_o = 1'b0;
        forever
        begin
            #(HALF_PERIOD);
            clk_o = ~clk_o;
        end
    end

endmodule
